// ==== Makefile ====
# Verilator build and run of the motion core testbench

VERILATOR ?= verilator
TOP       ?= motion_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
design/motion_pkg.sv
design/cmd_pkg.sv
design/command_decoder.sv
design/move_slot_buffer.sv
design/dda_tick_divider.sv
design/move_sequencer.sv
design/dda_axis.sv
design/motion_top.sv
tb/motion_assert.sv
tb/motion_tb.sv

// ==== design/cmd_pkg.sv ====
// Host command encodings
`default_nettype none

package cmd_pkg;

  localparam int word_bits  = 64;

  // Opcode sits in the top byte of a header word
  localparam int opcode_msb = 63;
  localparam int opcode_lsb = 56;

  localparam logic [7:0] cmd_coordinated_step = 8'h01;
  localparam logic [7:0] cmd_motor_enable     = 8'h0a;
  localparam logic [7:0] cmd_motor_brake      = 8'h0b;
  localparam logic [7:0] cmd_clk_divisor      = 8'h20;
  localparam logic [7:0] cmd_api_version      = 8'hfe;

  // API version reported to the host
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd4;
  localparam logic [7:0] version_patch = 8'd2;
  localparam logic [7:0] version_devel = 8'd0;

  // Duration word, then increment and incrementincrement per motor
  localparam int move_words = 1 + 2 * motion_pkg::num_motors;

endpackage

`default_nettype wire

// ==== design/command_decoder.sv ====
// Host command decoder
`default_nettype none
`timescale 1ns/100ps

module command_decoder import motion_pkg::*, cmd_pkg::*; (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic [word_bits-1:0]    word_data_received,
  input  logic                    word_received,
  output logic [word_bits-1:0]    word_send_data,
  output logic [num_motors-1:0]   enable,
  output logic [num_motors-1:0]   brake,
  output logic [divisor_bits-1:0] divisor,
  output move_hdr_t               hdr_wdata,
  output axis_param_t             axis_wdata,
  output slot_idx_t               write_slot,
  output logic                    slot_commit
);

  logic       word_rcv_q;
  logic       word_rcv_qq;
  logic       word_rise;
  logic [7:0] message_header;
  logic [7:0] word_count;
  logic [7:0] opcode;
  logic       awaiting_more_words;
  logic       last_word;

  // Strobe is sampled once, then delayed once more for the edge
  assign word_rise = word_rcv_q & ~word_rcv_qq;
  assign opcode    = word_data_received[opcode_msb:opcode_lsb];

  assign awaiting_more_words = (message_header == cmd_coordinated_step) |
                               (message_header == cmd_api_version);

  assign last_word = word_rise && (message_header == cmd_coordinated_step) &&
                     (word_count == 8'(move_words));

  // Control registers, message state and reply word
  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_rcv_q     <= 1'b0;
      word_rcv_qq    <= 1'b0;
      message_header <= 8'd0;
      word_count     <= 8'd0;
      enable         <= '0;
      brake          <= '0;
      divisor        <= default_divisor;
      word_send_data <= '0;
      write_slot     <= '0;
      slot_commit    <= 1'b0;
    end else begin
      word_rcv_q  <= word_received;
      word_rcv_qq <= word_rcv_q;
      slot_commit <= last_word;  // Payload is complete one cycle later

      if (slot_commit)
        write_slot <= write_slot + 1'b1;

      if (word_rise) begin
        word_send_data <= '0;  // Reply is zero unless set below

        if (!awaiting_more_words) begin
          message_header <= opcode;
          word_count     <= 8'd1;
          case (opcode)
            cmd_motor_enable: enable  <= word_data_received[num_motors-1:0];
            cmd_motor_brake:  brake   <= word_data_received[num_motors-1:0];
            cmd_clk_divisor:  divisor <= word_data_received[divisor_bits-1:0];
            cmd_api_version: begin
              word_send_data <= {{(word_bits-32){1'b0}}, version_devel,
                                 version_major, version_minor, version_patch};
            end
            default: ;
          endcase
        end else begin
          word_count <= word_count + 8'd1;
          // Message ends after the last move word or the version filler
          if (last_word || message_header != cmd_coordinated_step) begin
            message_header <= 8'd0;
            word_count     <= 8'd0;
          end
        end
      end
    end
  end

  // Move payload assembled word by word
  always_ff @(posedge CLK) begin
    if (word_rise) begin
      if (!awaiting_more_words) begin
        if (opcode == cmd_coordinated_step)
          hdr_wdata.dir <= word_data_received[num_motors-1:0];
      end else if (message_header == cmd_coordinated_step) begin
        if (word_count == 8'd1)
          hdr_wdata.duration <= word_data_received[duration_bits-1:0];
        for (int m = 0; m < num_motors; m++) begin
          if (word_count == 8'(2 + 2 * m))
            axis_wdata.increment[m] <= word_data_received[dda_bits-1:0];
          if (word_count == 8'(3 + 2 * m))
            axis_wdata.incrementincrement[m] <= word_data_received[dda_bits-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dda_axis.sv ====
// Second-order DDA axis
`default_nettype none
`timescale 1ns/100ps

module dda_axis import motion_pkg::*; (
  input  logic                CLK,
  input  logic                resetn,
  input  logic                dda_tick,
  input  logic                load_move,
  input  logic                executing,
  input  logic [dda_bits-1:0] increment,
  input  logic [dda_bits-1:0] incrementincrement,
  output logic                step
);

  logic signed [dda_bits-1:0] accum;
  logic signed [dda_bits-1:0] rate;   // Running increment
  logic signed [dda_bits-1:0] accum_next;

  assign accum_next = accum + rate;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      accum <= '0;
      rate  <= '0;
      step  <= 1'b0;
    end else begin
      step <= 1'b0;
      if (load_move) begin
        accum <= '0;
        rate  <= increment;  // Run slot already points at the new move
      end else if (executing && dda_tick) begin
        accum <= accum_next;
        rate  <= rate + incrementincrement;
        // A change of the boundary bit is one step
        step  <= accum_next[step_bit] ^ accum[step_bit];
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dda_tick_divider.sv ====
// DDA tick divider
`default_nettype none
`timescale 1ns/100ps

module dda_tick_divider import motion_pkg::*; (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic [divisor_bits-1:0] divisor,
  output logic                    dda_tick
);

  logic [divisor_bits-1:0] count;
  logic [divisor_bits-1:0] reload;

  // Shortest period is two cycles
  assign reload = (divisor < 2) ? divisor_bits'(2) : divisor;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      count    <= '0;
      dda_tick <= 1'b0;
    end else if (count == '0) begin
      count    <= reload - 1'b1;  // New divisor taken at wrap
      dda_tick <= 1'b1;
    end else begin
      count    <= count - 1'b1;
      dda_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/motion_pkg.sv ====
// Motion core definitions
`default_nettype none

package motion_pkg;

  localparam int num_motors    = 2;
  localparam int dda_bits      = 64;  // Accumulator and increment width
  localparam int duration_bits = 32;  // Move length in DDA ticks
  localparam int buffer_slots  = 2;
  localparam int step_bit      = 32;  // Fixed-point boundary of the accumulator
  localparam int divisor_bits  = 8;

  localparam logic [divisor_bits-1:0] default_divisor = 8'd32;

  typedef logic [$clog2(buffer_slots)-1:0] slot_idx_t;

  // Move header held per slot
  typedef struct packed {
    logic [duration_bits-1:0] duration;
    logic [num_motors-1:0]    dir;
  } move_hdr_t;

  // Second-order DDA parameters for every motor
  typedef struct packed {
    logic [num_motors-1:0][dda_bits-1:0] increment;
    logic [num_motors-1:0][dda_bits-1:0] incrementincrement;
  } axis_param_t;

endpackage

`default_nettype wire

// ==== design/motion_top.sv ====
// Motion controller core
`default_nettype none
`timescale 1ns/100ps

module motion_top import motion_pkg::*, cmd_pkg::*; (
  input  wire                   CLK,
  input  wire                   resetn,
  input  wire [word_bits-1:0]   word_data_received,
  input  wire                   word_received,
  output wire [word_bits-1:0]   word_send_data,
  output wire                   buffer_dtr,
  output wire                   move_done,
  output wire [num_motors-1:0]  step,
  output wire [num_motors-1:0]  dir,
  output wire [num_motors-1:0]  enable,
  output wire [num_motors-1:0]  brake
);

  logic [divisor_bits-1:0] divisor;
  move_hdr_t               hdr_wdata;
  move_hdr_t               hdr_rdata;
  axis_param_t             axis_wdata;
  axis_param_t             axis_rdata;
  slot_idx_t               write_slot;
  slot_idx_t               run_slot;
  logic                    slot_commit;
  logic                    dda_tick;
  logic                    load_move;
  logic                    executing;

  command_decoder u_command_decoder (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .enable             (enable),
    .brake              (brake),
    .divisor            (divisor),
    .hdr_wdata          (hdr_wdata),
    .axis_wdata         (axis_wdata),
    .write_slot         (write_slot),
    .slot_commit        (slot_commit)
  );

  // Duration and dir per slot
  move_slot_buffer #(.payload_t(move_hdr_t)) u_hdr_buffer (
    .CLK     (CLK),
    .resetn  (resetn),
    .wr_en   (slot_commit),
    .wr_slot (write_slot),
    .wr_data (hdr_wdata),
    .rd_slot (run_slot),
    .rd_data (hdr_rdata)
  );

  move_slot_buffer #(.payload_t(axis_param_t)) u_axis_buffer (
    .CLK     (CLK),
    .resetn  (resetn),
    .wr_en   (slot_commit),
    .wr_slot (write_slot),
    .wr_data (axis_wdata),
    .rd_slot (run_slot),
    .rd_data (axis_rdata)
  );

  dda_tick_divider u_dda_tick_divider (
    .CLK      (CLK),
    .resetn   (resetn),
    .divisor  (divisor),
    .dda_tick (dda_tick)
  );

  move_sequencer u_move_sequencer (
    .CLK         (CLK),
    .resetn      (resetn),
    .dda_tick    (dda_tick),
    .slot_commit (slot_commit),
    .write_slot  (write_slot),
    .duration    (hdr_rdata.duration),
    .run_slot    (run_slot),
    .load_move   (load_move),
    .executing   (executing),
    .move_done   (move_done),
    .buffer_dtr  (buffer_dtr)
  );

  assign dir = hdr_rdata.dir;  // Follows the running slot

  for (genvar i = 0; i < num_motors; i++) begin : g_axis
    dda_axis u_dda_axis (
      .CLK                (CLK),
      .resetn             (resetn),
      .dda_tick           (dda_tick),
      .load_move          (load_move),
      .executing          (executing),
      .increment          (axis_rdata.increment[i]),
      .incrementincrement (axis_rdata.incrementincrement[i]),
      .step               (step[i])
    );
  end

endmodule

`default_nettype wire

// ==== design/move_sequencer.sv ====
// Move sequencer
`default_nettype none
`timescale 1ns/100ps

module move_sequencer import motion_pkg::*; (
  input  logic                     CLK,
  input  logic                     resetn,
  input  logic                     dda_tick,
  input  logic                     slot_commit,
  input  slot_idx_t                write_slot,
  input  logic [duration_bits-1:0] duration,
  output slot_idx_t                run_slot,
  output logic                     load_move,
  output logic                     executing,
  output logic                     move_done,
  output logic                     buffer_dtr
);

  logic [buffer_slots-1:0]  commit_tgl;  // Flipped by the decoder side
  logic [buffer_slots-1:0]  done_tgl;    // Flipped on completion
  logic [buffer_slots-1:0]  ready;
  logic [duration_bits-1:0] tick_count;
  logic [duration_bits-1:0] tick_next;
  logic                     final_tick;
  slot_idx_t                next_slot;
  logic                     start;

  assign ready      = commit_tgl ^ done_tgl;
  assign buffer_dtr = ~ready[write_slot];

  assign tick_next  = tick_count + 1'b1;
  assign final_tick = executing && dda_tick && (tick_next >= duration);

  // Final tick of one move doubles as the start of the next
  assign next_slot = final_tick ? slot_idx_t'(run_slot + 1'b1) : run_slot;
  assign start     = dda_tick && (!executing || final_tick) && ready[next_slot];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      commit_tgl <= '0;
      done_tgl   <= '0;
      run_slot   <= '0;
      executing  <= 1'b0;
      tick_count <= '0;
      load_move  <= 1'b0;
      move_done  <= 1'b0;
    end else begin
      load_move <= start;
      move_done <= final_tick;

      if (slot_commit)
        commit_tgl[write_slot] <= ~commit_tgl[write_slot];

      if (final_tick) begin
        done_tgl[run_slot] <= ~done_tgl[run_slot];  // Frees the slot
        run_slot           <= run_slot + 1'b1;
      end

      if (start) begin
        executing  <= 1'b1;
        tick_count <= '0;
      end else if (final_tick) begin
        executing <= 1'b0;
      end else if (executing && dda_tick) begin
        tick_count <= tick_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/move_slot_buffer.sv ====
// Move slot store
`default_nettype none
`timescale 1ns/100ps

module move_slot_buffer import motion_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic      CLK,
  input  logic      resetn,
  input  logic      wr_en,
  input  slot_idx_t wr_slot,
  input  payload_t  wr_data,
  input  slot_idx_t rd_slot,
  output payload_t  rd_data
);

  payload_t slots [buffer_slots];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      for (int i = 0; i < buffer_slots; i++) begin
        slots[i] <= '0;
      end
    end else if (wr_en) begin
      slots[wr_slot] <= wr_data;  // One whole move per commit
    end
  end

  // Executing slot seen without delay
  assign rd_data = slots[rd_slot];

endmodule

`default_nettype wire

// ==== tb/motion_assert.sv ====
// Motion core port assertions
`default_nettype none
`timescale 1ns/100ps

module motion_assert import motion_pkg::*, cmd_pkg::*; (
  input wire                  CLK,
  input wire                  resetn,
  input wire [word_bits-1:0]  word_send_data,
  input wire                  buffer_dtr,
  input wire                  move_done,
  input wire [num_motors-1:0] step
);

  // Done is a single-cycle pulse
  done_pulse: assert property (@(posedge CLK) disable iff (resetn)
    move_done |=> !move_done)
    else $error("move_done held high for two cycles");

  step_pulse: assert property (@(posedge CLK) disable iff (resetn)
    (step & $past(step)) == '0)  // Ticks are at least two cycles apart
    else $error("step high in two consecutive cycles");

  dtr_after_reset: assert property (@(posedge CLK)
    $fell(resetn) |-> buffer_dtr)
    else $error("buffer_dtr low in the first cycle after reset");

  // First reset edge has not loaded the reply register yet
  reply_in_reset: assert property (@(posedge CLK)
    resetn && $past(resetn) |-> word_send_data == '0)
    else $error("word_send_data not zero during reset");

endmodule

bind motion_top motion_assert u_motion_assert (
  .CLK            (CLK),
  .resetn         (resetn),
  .word_send_data (word_send_data),
  .buffer_dtr     (buffer_dtr),
  .move_done      (move_done),
  .step           (step)
);

`default_nettype wire

// ==== tb/motion_tb.sv ====
// Motion core testbench
`default_nettype none
`timescale 1ns/100ps

module motion_tb import motion_pkg::*, cmd_pkg::*; ();

  localparam int unsigned single_duration = 40;
  localparam int unsigned first_duration  = 40;
  localparam int unsigned second_duration = 30;
  localparam int unsigned fast_divisor    = 5;
  localparam int unsigned watchdog_cycles = single_duration * int'(default_divisor) +
                                            (first_duration + second_duration) * fast_divisor +
                                            3000;

  logic                  CLK = 1'b0;
  logic                  resetn;
  logic [word_bits-1:0]  word_data_received;
  logic                  word_received;
  logic [word_bits-1:0]  word_send_data;
  logic                  buffer_dtr;
  logic                  move_done;
  logic [num_motors-1:0] step;
  logic [num_motors-1:0] dir;
  logic [num_motors-1:0] enable;
  logic [num_motors-1:0] brake;

  // Parameters of the three moves used by the tests
  logic [num_motors-1:0] mv_dir [3];
  int unsigned           mv_dur [3];
  logic [dda_bits-1:0]   mv_inc [3][num_motors];
  logic [dda_bits-1:0]   mv_incinc [3][num_motors];

  int unsigned cycle = 0;
  int unsigned step_count [num_motors];
  int unsigned done_count;
  int unsigned done_cycle [$];
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned test_errors = 0;
  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  string       test_name;

  motion_top u_motion_top (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .buffer_dtr         (buffer_dtr),
    .move_done          (move_done),
    .step               (step),
    .dir                (dir),
    .enable             (enable),
    .brake              (brake)
  );

  always #2 CLK = ~CLK;

  always @(posedge CLK) cycle <= cycle + 1;

  // Pulses sampled mid-cycle, where the outputs are stable
  always @(negedge CLK) begin
    if (resetn) begin
      done_count = 0;
      done_cycle.delete();
      for (int m = 0; m < num_motors; m++) step_count[m] = 0;
    end else begin
      for (int m = 0; m < num_motors; m++) begin
        if (step[m]) step_count[m] = step_count[m] + 1;
      end
      if (move_done) begin
        done_count = done_count + 1;
        done_cycle.push_back(cycle);
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  // Steps of one move from the second-order accumulator rule
  function automatic int unsigned expected_steps(input int unsigned duration,
                                                 input logic [dda_bits-1:0] inc,
                                                 input logic [dda_bits-1:0] incinc);
    logic [dda_bits-1:0] acc;
    logic [dda_bits-1:0] acc_next;
    logic [dda_bits-1:0] rate;
    int unsigned         steps;
    acc   = '0;
    rate  = inc;
    steps = 0;
    for (int unsigned t = 0; t < duration; t++) begin
      acc_next = acc + rate;
      if (acc_next[step_bit] != acc[step_bit]) steps++;
      acc  = acc_next;
      rate = rate + incinc;
    end
    return steps;
  endfunction

  function automatic logic [word_bits-1:0] command_word(input logic [7:0] opcode,
                                                         input logic [word_bits-9:0] value);
    return {opcode, value};
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, test_errors);
    end
  endtask

  task automatic send_word(input logic [word_bits-1:0] data);
    @(negedge CLK);
    word_data_received = data;
    word_received      = 1'b1;
    repeat (4) @(negedge CLK);
    word_received = 1'b0;
    repeat (4) @(negedge CLK);
  endtask

  task automatic wait_for_dtr(input int unsigned limit);
    int unsigned waited;
    waited = 0;
    while (!buffer_dtr && waited < limit) begin
      @(negedge CLK);
      waited++;
    end
    if (!buffer_dtr) begin
      $display("Timeout in %s: buffer_dtr stayed low for %0d cycles", test_name, limit);
      errors++;
      test_errors++;
    end
  endtask

  task automatic wait_for_done(input int unsigned target, input int unsigned limit);
    int unsigned waited;
    waited = 0;
    while (done_count < target && waited < limit) begin
      @(posedge CLK);
      waited++;
    end
    if (done_count < target) begin
      $display("Timeout in %s: saw %0d move_done pulses, waiting for %0d", test_name,
               done_count, target);
      errors++;
      test_errors++;
    end
  endtask

  task automatic pick_move(input int idx, input int unsigned duration);
    mv_dur[idx] = duration;
    mv_dir[idx] = num_motors'($urandom_range(3, 1));
    for (int m = 0; m < num_motors; m++) begin
      mv_inc[idx][m]    = dda_bits'($urandom_range(32'h4000_0000, 32'h0800_0000));
      mv_incinc[idx][m] = dda_bits'($urandom_range(32'h0040_0000, 0));
    end
  endtask

  task automatic send_move(input int idx);
    wait_for_dtr(watchdog_cycles);
    send_word(command_word(cmd_coordinated_step, (word_bits-8)'(mv_dir[idx])));
    send_word(word_bits'(mv_dur[idx]));
    for (int m = 0; m < num_motors; m++) begin
      send_word(mv_inc[idx][m]);
      send_word(mv_incinc[idx][m]);
    end
  endtask

  initial begin
    int unsigned base_done;
    int unsigned base_steps [num_motors];
    int unsigned spacing;
    void'($urandom(32'hd055_77ff));
    resetn             = 1'b1;
    word_received      = 1'b0;
    word_data_received = '0;
    repeat (3) @(negedge CLK);
    resetn = 1'b0;
    @(negedge CLK);

    begin_test("reset_state");
    check_value("buffer_dtr", 1, buffer_dtr);
    check_value("move_done", 0, move_done);
    check_value("step", 0, step);
    check_value("enable", 0, enable);
    check_value("brake", 0, brake);
    check_value("word_send_data", 0, word_send_data);
    end_test();

    begin_test("enable_brake");
    send_word(command_word(cmd_motor_enable, 56'h5a5a_0001));  // Only the low bits count
    check_value("enable", 2'b01, enable);
    send_word(command_word(cmd_motor_brake, 56'h0000_0002));
    check_value("brake", 2'b10, brake);
    check_value("enable kept", 2'b01, enable);
    end_test();

    begin_test("api_version");
    send_word(command_word(cmd_api_version, '0));
    check_value("version word",
                {32'h0, version_devel, version_major, version_minor, version_patch},
                word_send_data);
    send_word(64'h0123_4567_89ab_cdef);
    check_value("filler reply", 0, word_send_data);
    end_test();

    begin_test("single_move");
    pick_move(0, single_duration);
    base_done = done_count;
    for (int m = 0; m < num_motors; m++) base_steps[m] = step_count[m];
    send_move(0);
    // Start tick is at most one divisor period after the commit
    repeat (3 * int'(default_divisor)) @(negedge CLK);
    check_value("dir", mv_dir[0], dir);
    wait_for_done(base_done + 1, single_duration * int'(default_divisor) + 200);
    repeat (4 * int'(default_divisor)) @(posedge CLK);
    check_value("move_done count", base_done + 1, done_count);
    for (int m = 0; m < num_motors; m++) begin
      check_value($sformatf("motor %0d steps", m),
                  base_steps[m] + expected_steps(mv_dur[0], mv_inc[0][m], mv_incinc[0][m]),
                  step_count[m]);
    end
    end_test();

    begin_test("back_to_back");
    send_word(command_word(cmd_clk_divisor, (word_bits-8)'(fast_divisor)));
    pick_move(1, first_duration);
    pick_move(2, second_duration);
    base_done = done_count;
    for (int m = 0; m < num_motors; m++) base_steps[m] = step_count[m];
    send_move(1);
    send_move(2);
    check_value("buffer_dtr with both slots full", 0, buffer_dtr);
    wait_for_done(base_done + 2, (first_duration + second_duration) * int'(default_divisor) + 400);
    repeat (4 * int'(default_divisor)) @(posedge CLK);
    check_value("move_done count", base_done + 2, done_count);
    spacing = 0;
    if (done_cycle.size() >= 2) spacing = done_cycle[$] - done_cycle[$-1];
    check_value("move_done spacing", second_duration * fast_divisor, spacing);
    for (int m = 0; m < num_motors; m++) begin
      check_value($sformatf("motor %0d steps", m),
                  base_steps[m] +
                  expected_steps(mv_dur[1], mv_inc[1][m], mv_incinc[1][m]) +
                  expected_steps(mv_dur[2], mv_inc[2][m], mv_incinc[2][m]),
                  step_count[m]);
    end
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests_run, tests_failed,
             checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
